// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module letc_core_tb -o Vletc_core_tb

run: build
	./obj_dir/Vletc_core_tb 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	verilator --lint-only -Wall -f build.f --top-module letc_core_top

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+common
common/letc_core_pkg.sv
rtl/letc_core_rf.sv
rtl/letc_core_stage_f.sv
rtl/letc_core_stage_d.sv
rtl/letc_core_stage_e.sv
rtl/letc_core_stage_w.sv
rtl/letc_core_tghm.sv
rtl/letc_core_top.sv
tb/letc_core_clkgen.sv
tb/letc_core_tb.sv

// File: common/letc_core_macros.svh
/*
 * Core-wide constants. The register count must stay a power of two
 * because the register index width is derived from it.
*/

`ifndef LETC_CORE_MACROS_SVH
`define LETC_CORE_MACROS_SVH

//PC loaded on reset, first fetch address
`define LETC_RESET_PC 32'h0000_0000

//Architectural integer registers, x0 included
`define LETC_NUM_REGS 32

//Fixed 32-bit encodings only, no compressed instructions
`define LETC_INST_WIDTH 32

`endif

// File: common/letc_core_pkg.sv
/*
 * Shared types of the core. Only the RV32I subset the core executes
 * has opcodes here; anything else decodes as a no-op.
*/

`default_nettype none

`include "letc_core_macros.svh"

package letc_core_pkg;

typedef logic [31:0] word_t;
typedef logic [$clog2(`LETC_NUM_REGS)-1:0] reg_idx_t;

typedef enum logic [6:0] {
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_BRANCH = 7'b1100011
} opcode_e;

typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
} alu_op_e;

//One instruction word, read through whichever format view decode needs
typedef union packed {
    logic [`LETC_INST_WIDTH-1:0] raw;
    struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r;
    struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i;
    struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s;
    struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b;
    struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        opcode_e     opcode;
    } u;
} inst_u;

typedef struct packed {
    logic  valid;
    word_t pc;
    inst_u inst;
} f_to_d_s;

typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    rs1_rdata;
    word_t    rs2_rdata;
    word_t    imm;
    reg_idx_t rd;
    logic     wen;
    alu_op_e  alu_op;
    //Operand B is the immediate instead of rs2
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     branch_ne;
} d_to_e_s;

typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     wen;
    word_t    alu_result;
    logic     is_load;
    word_t    load_data;
} e_to_w_s;

typedef struct packed {
    logic  wen;
    word_t addr;
    word_t wdata;
} dmem_req_s;

endpackage : letc_core_pkg

`default_nettype wire

// File: rtl/letc_core_rf.sv
/*
 * Register file with two combinational read ports and one write port.
 * A read of the register written this cycle sees the new value.
*/

`default_nettype none

`include "letc_core_macros.svh"

module letc_core_rf
    import letc_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,

    //rd write port
    input  reg_idx_t i_rd_idx,
    input  word_t    i_rd_wdata,
    input  logic     i_rd_wen,

    //rs1 read port
    input  reg_idx_t i_rs1_idx,
    output word_t    o_rs1_rdata,

    //rs2 read port
    input  reg_idx_t i_rs2_idx,
    output word_t    o_rs2_rdata
);

word_t regs [`LETC_NUM_REGS];

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        for (int i = 0; i < `LETC_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (i_rd_wen && (i_rd_idx != '0)) begin
        regs[i_rd_idx] <= i_rd_wdata;
    end
end

//x0 first, then write-through, then the array
always_comb begin
    if (i_rs1_idx == '0) begin
        o_rs1_rdata = '0;
    end else if (i_rd_wen && (i_rd_idx == i_rs1_idx)) begin
        o_rs1_rdata = i_rd_wdata;
    end else begin
        o_rs1_rdata = regs[i_rs1_idx];
    end

    if (i_rs2_idx == '0) begin
        o_rs2_rdata = '0;
    end else if (i_rd_wen && (i_rd_idx == i_rs2_idx)) begin
        o_rs2_rdata = i_rd_wdata;
    end else begin
        o_rs2_rdata = regs[i_rs2_idx];
    end
end

endmodule : letc_core_rf

`default_nettype wire

// File: rtl/letc_core_stage_d.sv
/*
 * Decode stage. Without forwarding it holds any instruction whose source
 * is written by the instruction in E; a writer in W is covered by the
 * register file write-through. Unsupported encodings pass on as no-ops.
*/

`default_nettype none

module letc_core_stage_d
    import letc_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,

    //Hazard signals
    input  logic     i_stage_stall,
    input  logic     i_stage_flush,
    output logic     o_stage_ready,

    //From F
    input  f_to_d_s  i_f_to_d,

    //Destination of the instruction in E
    input  reg_idx_t i_e_rd,
    input  logic     i_e_wen,

    //Register file read ports
    output reg_idx_t o_rs1_idx,
    input  word_t    i_rs1_rdata,
    output reg_idx_t o_rs2_idx,
    input  word_t    i_rs2_rdata,

    //To E
    output d_to_e_s  o_d_to_e
);

inst_u   inst;
word_t   imm_i;
word_t   imm_s;
word_t   imm_b;
word_t   imm_u;
logic    uses_rs1;
logic    uses_rs2;
d_to_e_s d_to_e_next;

assign inst = i_f_to_d.inst;

//rs1 and rs2 sit at the same bits in every format that has them
assign o_rs1_idx = inst.r.rs1;
assign o_rs2_idx = inst.r.rs2;

//Sign-extended immediates
assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
assign imm_u = {inst.u.imm_31_12, 12'h000};

always_comb begin
    d_to_e_next           = '0;
    d_to_e_next.pc        = i_f_to_d.pc;
    d_to_e_next.rs1_rdata = i_rs1_rdata;
    d_to_e_next.rs2_rdata = i_rs2_rdata;
    d_to_e_next.rd        = inst.r.rd;
    d_to_e_next.alu_op    = ALU_ADD;
    uses_rs1              = 1'b0;
    uses_rs2              = 1'b0;

    unique case (inst.r.opcode)
        OPCODE_OP: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            d_to_e_next.wen = 1'b1;
            //funct7 only selects SUB; other funct7 values are no-ops
            case ({inst.r.funct7, inst.r.funct3})
                10'b0000000_000: d_to_e_next.alu_op = ALU_ADD;
                10'b0100000_000: d_to_e_next.alu_op = ALU_SUB;
                10'b0000000_100: d_to_e_next.alu_op = ALU_XOR;
                10'b0000000_110: d_to_e_next.alu_op = ALU_OR;
                10'b0000000_111: d_to_e_next.alu_op = ALU_AND;
                default:         d_to_e_next.wen    = 1'b0;
            endcase
        end
        OPCODE_OP_IMM: begin
            //ADDI only
            uses_rs1             = 1'b1;
            d_to_e_next.imm      = imm_i;
            d_to_e_next.use_imm  = 1'b1;
            d_to_e_next.wen      = (inst.i.funct3 == 3'b000);
        end
        OPCODE_LUI: begin
            d_to_e_next.imm      = imm_u;
            d_to_e_next.use_imm  = 1'b1;
            d_to_e_next.alu_op   = ALU_PASS_B;
            d_to_e_next.wen      = 1'b1;
        end
        OPCODE_LOAD: begin
            //LW only
            uses_rs1             = 1'b1;
            d_to_e_next.imm      = imm_i;
            d_to_e_next.is_load  = (inst.i.funct3 == 3'b010);
            d_to_e_next.wen      = (inst.i.funct3 == 3'b010);
        end
        OPCODE_STORE: begin
            //SW only
            uses_rs1             = 1'b1;
            uses_rs2             = 1'b1;
            d_to_e_next.imm      = imm_s;
            d_to_e_next.is_store = (inst.s.funct3 == 3'b010);
        end
        OPCODE_BRANCH: begin
            //BEQ and BNE
            uses_rs1              = 1'b1;
            uses_rs2              = 1'b1;
            d_to_e_next.imm       = imm_b;
            d_to_e_next.is_branch = (inst.b.funct3[2:1] == 2'b00);
            d_to_e_next.branch_ne = inst.b.funct3[0];
        end
        default: begin
            //Anything else retires doing nothing
        end
    endcase

    //Bubble into E on stall, drop the instruction on flush
    d_to_e_next.valid = i_f_to_d.valid && !i_stage_stall && !i_stage_flush;
end

//RAW against the writer in E; i_e_wen already excludes x0
assign o_stage_ready = !(i_f_to_d.valid && i_e_wen &&
                         ((uses_rs1 && (o_rs1_idx == i_e_rd)) ||
                          (uses_rs2 && (o_rs2_idx == i_e_rd))));

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_d_to_e.valid <= 1'b0;
    end else begin
        o_d_to_e <= d_to_e_next;
    end
end

endmodule : letc_core_stage_d

`default_nettype wire

// File: rtl/letc_core_stage_e.sv
/*
 * Execute stage: ALU, branch resolution and the data-memory access.
 * The data memory must answer loads in the same cycle; a store is
 * committed on the edge that ends its cycle in E.
*/

`default_nettype none

module letc_core_stage_e
    import letc_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,

    //Hazard signals
    input  logic      i_stage_flush,
    output logic      o_stage_ready,

    //From D
    input  d_to_e_s   i_d_to_e,

    //Destination seen by the D hazard check
    output reg_idx_t  o_e_rd,
    output logic      o_e_wen,

    //Branch redirect to F and tghm
    output logic      o_redirect,
    output word_t     o_redirect_pc,

    //Data memory
    output dmem_req_s o_dmem_req,
    input  word_t     i_dmem_rdata,

    //To W
    output e_to_w_s   o_e_to_w
);

word_t   alu_b;
word_t   alu_result;
word_t   mem_addr;
logic    operands_eq;
e_to_w_s e_to_w_next;

//Execute has no multi-cycle work
assign o_stage_ready = 1'b1;

assign alu_b = i_d_to_e.use_imm ? i_d_to_e.imm : i_d_to_e.rs2_rdata;

always_comb begin
    unique case (i_d_to_e.alu_op)
        ALU_ADD:    alu_result = i_d_to_e.rs1_rdata + alu_b;
        ALU_SUB:    alu_result = i_d_to_e.rs1_rdata - alu_b;
        ALU_AND:    alu_result = i_d_to_e.rs1_rdata & alu_b;
        ALU_OR:     alu_result = i_d_to_e.rs1_rdata | alu_b;
        ALU_XOR:    alu_result = i_d_to_e.rs1_rdata ^ alu_b;
        ALU_PASS_B: alu_result = alu_b;
        default:    alu_result = '0;
    endcase
end

//Branch compare, BNE inverts the sense
assign operands_eq   = (i_d_to_e.rs1_rdata == i_d_to_e.rs2_rdata);
assign o_redirect    = i_d_to_e.valid && i_d_to_e.is_branch &&
                       (operands_eq != i_d_to_e.branch_ne);
assign o_redirect_pc = i_d_to_e.pc + i_d_to_e.imm;

//Loads and stores share one address adder
assign mem_addr         = i_d_to_e.rs1_rdata + i_d_to_e.imm;
assign o_dmem_req.wen   = i_d_to_e.valid && i_d_to_e.is_store;
assign o_dmem_req.addr  = mem_addr;
assign o_dmem_req.wdata = i_d_to_e.rs2_rdata;

//Writes to x0 are never a hazard
assign o_e_rd  = i_d_to_e.rd;
assign o_e_wen = i_d_to_e.valid && i_d_to_e.wen && (i_d_to_e.rd != '0);

always_comb begin
    e_to_w_next.valid      = i_d_to_e.valid && !i_stage_flush;
    e_to_w_next.rd         = i_d_to_e.rd;
    e_to_w_next.wen        = i_d_to_e.wen;
    e_to_w_next.alu_result = alu_result;
    e_to_w_next.is_load    = i_d_to_e.is_load;
    e_to_w_next.load_data  = i_dmem_rdata;
end

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_e_to_w.valid <= 1'b0;
    end else begin
        o_e_to_w <= e_to_w_next;
    end
end

endmodule : letc_core_stage_e

`default_nettype wire

// File: rtl/letc_core_stage_f.sv
/*
 * Fetch stage. The instruction memory must answer in the same cycle
 * the address is presented; there is no fetch back-pressure.
*/

`default_nettype none

`include "letc_core_macros.svh"

module letc_core_stage_f
    import letc_core_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,

    //Hazard signals
    input  logic    i_stage_stall,
    input  logic    i_stage_flush,
    output logic    o_stage_ready,

    //Branch redirect from E
    input  logic    i_redirect,
    input  word_t   i_redirect_pc,

    //Instruction memory
    output word_t   o_imem_addr,
    input  word_t   i_imem_rdata,

    //To D
    output f_to_d_s o_f_to_d
);

word_t pc;

//Fetch never waits on anything
assign o_stage_ready = 1'b1;
assign o_imem_addr   = pc;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        pc             <= `LETC_RESET_PC;
        o_f_to_d.valid <= 1'b0;
    end else begin
        //Redirect wins over both stall and sequential fetch
        if (i_redirect) begin
            pc <= i_redirect_pc;
        end else if (!i_stage_stall) begin
            pc <= pc + 32'd4;
        end

        //Flush drops the fetched word, stall keeps the old one
        if (i_stage_flush) begin
            o_f_to_d.valid <= 1'b0;
        end else if (!i_stage_stall) begin
            o_f_to_d.valid    <= 1'b1;
            o_f_to_d.pc       <= pc;
            o_f_to_d.inst.raw <= i_imem_rdata;
        end
    end
end

endmodule : letc_core_stage_f

`default_nettype wire

// File: rtl/letc_core_stage_w.sv
/*
 * Writeback stage. Purely combinational; the register file commits
 * the value on the edge that ends the cycle.
*/

`default_nettype none

module letc_core_stage_w
    import letc_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,

    //Hazard signals
    output logic     o_stage_ready,

    //From E
    input  e_to_w_s  i_e_to_w,

    //Register file write port
    output reg_idx_t o_rd_idx,
    output word_t    o_rd_wdata,
    output logic     o_rd_wen
);

//Writeback always completes in one cycle
assign o_stage_ready = 1'b1;

assign o_rd_idx = i_e_to_w.rd;

//Load data or ALU result
assign o_rd_wdata = i_e_to_w.is_load ? i_e_to_w.load_data : i_e_to_w.alu_result;

//Bubbles and x0 never write
assign o_rd_wen = i_e_to_w.valid && i_e_to_w.wen && (i_e_to_w.rd != '0);

endmodule : letc_core_stage_w

`default_nettype wire

// File: rtl/letc_core_tghm.sv
/*
 * Hazard unit. Stage order in all vectors is F, D, E, W from bit 0.
 * A not-ready stage stalls itself and everything before it; a taken
 * branch flushes F and D and overrides any stall.
*/

`default_nettype none

module letc_core_tghm (
    input  logic       i_clk,
    input  logic       i_reset,

    //Per-stage ready bits
    input  logic [3:0] i_stage_ready,

    //Taken branch from E
    input  logic       i_redirect,

    //Per-stage controls
    output logic [3:0] o_stage_stall,
    output logic [3:0] o_stage_flush
);

logic [3:0] stall_chain;

//Back-pressure runs from W towards F
always_comb begin
    stall_chain[3] = !i_stage_ready[3];
    for (int i = 2; i >= 0; i--) begin
        stall_chain[i] = stall_chain[i+1] || !i_stage_ready[i];
    end
end

//Only the two stages behind E hold wrong-path work
assign o_stage_flush = {2'b00, i_redirect, i_redirect};

//Flush has priority
assign o_stage_stall = stall_chain & ~o_stage_flush;

endmodule : letc_core_tghm

`default_nettype wire

// File: rtl/letc_core_top.sv
/*
 * Core top. Both memories are single-cycle combinational ports owned
 * by the environment; there is no bus interface.
*/

`default_nettype none

module letc_core_top
    import letc_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,

    //Instruction memory
    output word_t     o_imem_addr,
    input  word_t     i_imem_rdata,

    //Data memory
    output dmem_req_s o_dmem_req,
    input  word_t     i_dmem_rdata
);

//rd write port
reg_idx_t rd_idx;
word_t    rd_wdata;
logic     rd_wen;

//rs1 and rs2 read ports
reg_idx_t rs1_idx;
word_t    rs1_rdata;
reg_idx_t rs2_idx;
word_t    rs2_rdata;

//Inter-stage registers
f_to_d_s  f_to_d;
d_to_e_s  d_to_e;
e_to_w_s  e_to_w;

//Hazard signals, bit 0 is F
logic [3:0] stage_ready;
logic [3:0] stage_stall;
logic [3:0] stage_flush;

//E destination and branch redirect
reg_idx_t e_rd;
logic     e_wen;
logic     redirect;
word_t    redirect_pc;

letc_core_rf rf (
    .*,
    .i_rd_idx(rd_idx),
    .i_rd_wdata(rd_wdata),
    .i_rd_wen(rd_wen),
    .i_rs1_idx(rs1_idx),
    .o_rs1_rdata(rs1_rdata),
    .i_rs2_idx(rs2_idx),
    .o_rs2_rdata(rs2_rdata)
);

letc_core_stage_f stage_f (
    .*,
    .i_stage_stall(stage_stall[0]),
    .i_stage_flush(stage_flush[0]),
    .o_stage_ready(stage_ready[0]),
    .i_redirect(redirect),
    .i_redirect_pc(redirect_pc),
    .o_imem_addr(o_imem_addr),
    .i_imem_rdata(i_imem_rdata),
    .o_f_to_d(f_to_d)
);

letc_core_stage_d stage_d (
    .*,
    .i_stage_stall(stage_stall[1]),
    .i_stage_flush(stage_flush[1]),
    .o_stage_ready(stage_ready[1]),
    .i_f_to_d(f_to_d),
    .i_e_rd(e_rd),
    .i_e_wen(e_wen),
    .o_rs1_idx(rs1_idx),
    .i_rs1_rdata(rs1_rdata),
    .o_rs2_idx(rs2_idx),
    .i_rs2_rdata(rs2_rdata),
    .o_d_to_e(d_to_e)
);

//E has no stall input, it never holds
letc_core_stage_e stage_e (
    .*,
    .i_stage_flush(stage_flush[2]),
    .o_stage_ready(stage_ready[2]),
    .i_d_to_e(d_to_e),
    .o_e_rd(e_rd),
    .o_e_wen(e_wen),
    .o_redirect(redirect),
    .o_redirect_pc(redirect_pc),
    .o_dmem_req(o_dmem_req),
    .i_dmem_rdata(i_dmem_rdata),
    .o_e_to_w(e_to_w)
);

letc_core_stage_w stage_w (
    .*,
    .o_stage_ready(stage_ready[3]),
    .i_e_to_w(e_to_w),
    .o_rd_idx(rd_idx),
    .o_rd_wdata(rd_wdata),
    .o_rd_wen(rd_wen)
);

letc_core_tghm tghm (
    .*,
    .i_stage_ready(stage_ready),
    .i_redirect(redirect),
    .o_stage_stall(stage_stall),
    .o_stage_flush(stage_flush)
);

endmodule : letc_core_top

`default_nettype wire

// File: tb/letc_core_clkgen.sv
/*
 * Free-running clock with a 10 ns period and a power-on reset
 * that stays high for the first 5 rising edges.
*/

`default_nettype none

module letc_core_clkgen (
    output logic o_clk,
    output logic o_reset
);

timeunit 1ns;
timeprecision 100ps;

initial begin
    o_clk   = 1'b0;
    o_reset <= 1'b1;
    repeat (5) @(posedge o_clk);
    o_reset <= 1'b0;
end

//Half period of 5 ns
always #5 o_clk = ~o_clk;

endmodule : letc_core_clkgen

`default_nettype wire

// File: tb/letc_core_tb.sv
/*
 * Directed tests of the core with a 64-word program ROM and a 64-word data RAM.
 * Programs sit at the reset PC and end in a BEQ x0,x0,0 self loop.
*/

`default_nettype none

`include "letc_core_macros.svh"

module letc_core_tb
    import letc_core_pkg::*;
;

timeunit 1ns;
timeprecision 100ps;

localparam int NUM_TESTS    = 6;
localparam int TEST_CYCLES  = 200;
localparam word_t SELF_LOOP = 32'h0000_0063;

logic      clk;
logic      gen_reset;
logic      test_reset;
word_t     imem_addr;
word_t     imem_rdata;
dmem_req_s dmem_req;
word_t     dmem_rdata;

word_t     rom [64];
word_t     ram [64];
int        prog_len;
int        cycle;
dmem_req_s store_q [$];
int        store_cycle_q [$];
dmem_req_s exp_q [$];

letc_core_clkgen clkgen (
    .o_clk(clk),
    .o_reset(gen_reset)
);

letc_core_top uut (
    .i_clk(clk),
    .i_reset(gen_reset || test_reset),
    .o_imem_addr(imem_addr),
    .i_imem_rdata(imem_rdata),
    .o_dmem_req(dmem_req),
    .i_dmem_rdata(dmem_rdata)
);

//Both memories answer in the same cycle
assign imem_rdata = rom[imem_addr[7:2]];
assign dmem_rdata = ram[dmem_req.addr[7:2]];

//Store capture with cycle 0 as the first cycle out of reset
always @(posedge clk) begin
    if (gen_reset || test_reset) begin
        cycle <= 0;
    end else begin
        if (dmem_req.wen) begin
            store_q.push_back(dmem_req);
            store_cycle_q.push_back(cycle);
            ram[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
        cycle <= cycle + 1;
    end
end

task automatic stop_with_failure(input string what);
    begin
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    begin
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure("word mismatch");
        end
    end
endtask

task automatic check_req(input string name, input dmem_req_s exp, input dmem_req_s act);
    begin
        if (exp !== act) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure("store request mismatch");
        end
    end
endtask

//Instruction encoders
function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

function automatic word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

function automatic dmem_req_s store_of(input word_t addr, input word_t data);
    dmem_req_s req;
    begin
        req.wen   = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        return req;
    end
endfunction

//Self loops in the whole ROM and an address-based fill in the RAM
task automatic clear_memories;
    begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = SELF_LOOP;
            ram[i] <= 32'h5A5A_0000 | (i * 4);
        end
        prog_len = 0;
        store_q.delete();
        store_cycle_q.delete();
        exp_q.delete();
    end
endtask

task automatic emit(input word_t inst);
    begin
        rom[prog_len] = inst;
        prog_len++;
    end
endtask

task automatic reset_core;
    begin
        @(posedge clk);
        test_reset <= 1'b1;
        repeat (5) @(posedge clk);
        store_q.delete();
        store_cycle_q.delete();
        test_reset <= 1'b0;
        @(posedge clk);
        check_word("o_imem_addr", `LETC_RESET_PC, imem_addr);
    end
endtask

//Wait for the stores and make sure no extra one follows
task automatic wait_and_compare;
    begin
        while (store_q.size() < exp_q.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (store_q.size() != exp_q.size()) begin
            stop_with_failure("more stores than the program performs");
        end
        foreach (exp_q[i]) begin
            check_req("o_dmem_req", exp_q[i], store_q[i]);
        end
    end
endtask

task automatic alu_test;
    logic [11:0] a;
    logic [11:0] b;
    word_t       va;
    word_t       vb;
    begin
        a  = 12'($urandom);
        b  = 12'($urandom);
        va = sext12(a);
        vb = sext12(b);
        clear_memories();
        emit(addi_word(5'd1, 5'd0, a));
        emit(addi_word(5'd2, 5'd0, b));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        for (int r = 1; r <= 7; r++) begin
            emit(sw_word(5'(r), 5'd0, 12'((r - 1) * 4)));
        end
        exp_q.push_back(store_of(32'd0, va));
        exp_q.push_back(store_of(32'd4, vb));
        exp_q.push_back(store_of(32'd8, va + vb));
        exp_q.push_back(store_of(32'd12, va - vb));
        exp_q.push_back(store_of(32'd16, va & vb));
        exp_q.push_back(store_of(32'd20, va | vb));
        exp_q.push_back(store_of(32'd24, va ^ vb));
        reset_core();
        wait_and_compare();
    end
endtask

task automatic lui_test;
    begin
        clear_memories();
        emit({20'h12345, 5'd1, 7'b0110111});
        emit(addi_word(5'd1, 5'd1, 12'h678));
        emit(sw_word(5'd1, 5'd0, 12'd4));
        emit({20'hABCDF, 5'd2, 7'b0110111});
        emit(addi_word(5'd2, 5'd2, 12'hEEF));
        emit(sw_word(5'd2, 5'd0, 12'd8));
        exp_q.push_back(store_of(32'd4, (32'h12345 << 12) + sext12(12'h678)));
        exp_q.push_back(store_of(32'd8, (32'hABCDF << 12) + sext12(12'hEEF)));
        reset_core();
        wait_and_compare();
    end
endtask

task automatic raw_chain_test;
    word_t x1;
    word_t x2;
    begin
        x1 = 32'd1 + 32'd2;
        x2 = x1 + x1;
        clear_memories();
        emit(addi_word(5'd1, 5'd0, 12'd1));
        emit(addi_word(5'd1, 5'd1, 12'd2));
        emit(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        emit(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(sw_word(5'd3, 5'd0, 12'd8));
        exp_q.push_back(store_of(32'd8, x2 - x1));
        reset_core();
        wait_and_compare();
        //Store is instruction 4 and each of the four dependent pairs costs one stall
        check_word("store_cycle", 32'd10, 32'(store_cycle_q[0]));
    end
endtask

task automatic branch_test;
    begin
        clear_memories();
        emit(addi_word(5'd1, 5'd0, 12'd5));
        emit(addi_word(5'd2, 5'd0, 12'd5));
        emit(branch_word(13'd12, 5'd2, 5'd1, 3'b000));
        emit(sw_word(5'd1, 5'd0, 12'd0));
        emit(sw_word(5'd1, 5'd0, 12'd4));
        emit(branch_word(13'd8, 5'd2, 5'd1, 3'b001));
        emit(sw_word(5'd2, 5'd0, 12'd8));
        emit(addi_word(5'd3, 5'd0, 12'd77));
        emit(sw_word(5'd3, 5'd0, 12'd12));
        exp_q.push_back(store_of(32'd8, 32'd5));
        exp_q.push_back(store_of(32'd12, 32'd77));
        reset_core();
        wait_and_compare();
    end
endtask

task automatic load_test;
    word_t data;
    begin
        data = $urandom;
        clear_memories();
        @(posedge clk);
        ram[4] <= data;
        emit(i_type(12'd16, 5'd0, 3'b010, 5'd1, 7'b0000011));
        emit(addi_word(5'd1, 5'd1, 12'd1));
        emit(sw_word(5'd1, 5'd0, 12'd20));
        emit(addi_word(5'd0, 5'd0, 12'd99));
        emit(sw_word(5'd0, 5'd0, 12'd24));
        exp_q.push_back(store_of(32'd20, data + 32'd1));
        exp_q.push_back(store_of(32'd24, 32'd0));
        reset_core();
        wait_and_compare();
    end
endtask

task automatic reset_state_test;
    begin
        clear_memories();
        emit(addi_word(5'd1, 5'd0, 12'd9));
        emit(addi_word(5'd2, 5'd0, 12'd3));
        emit(addi_word(5'd3, 5'd0, 12'd4));
        emit(sw_word(5'd1, 5'd0, 12'd28));
        exp_q.push_back(store_of(32'd28, 32'd9));
        reset_core();
        wait_and_compare();
        //Store fetched in cycle 3 strobes two cycles later
        check_word("store_cycle", 32'd5, 32'(store_cycle_q[0]));
    end
endtask

initial begin
    test_reset <= 1'b1;
    prog_len   = 0;
    cycle      <= 0;
    for (int i = 0; i < 64; i++) begin
        rom[i] = SELF_LOOP;
        ram[i] <= 32'h5A5A_0000 | (i * 4);
    end
end

//Watchdog sized for every test plus the power-on reset
initial begin
    repeat (NUM_TESTS * TEST_CYCLES + 5) @(posedge clk);
    stop_with_failure("timeout waiting for the tests to finish");
end

initial begin
    void'($urandom(29));
    @(negedge gen_reset);
    reset_state_test();
    alu_test();
    lui_test();
    raw_chain_test();
    branch_test();
    load_test();
    $display("Simulation passed");
    $finish;
end

endmodule : letc_core_tb

`default_nettype wire
